// File: branch_unit.sv
`timescale 1ns/100ps
`include "dtp_settings.svh"

module branch_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_attr_we,
    input  logic [`DTP_ATTR_W-1:0] i_attr_addr,
    input  logic [`DTP_THSH_W-1:0] i_attr_din,
    trav_if.branch                 bus
);
    typedef logic [`DTP_THSH_W-1:0] attr_t;

    typedef struct packed {
        dtp_pkg::node_addr_t inc;     // address + 1
        dtp_pkg::node_addr_t tree_a;  // tree offset or absolute root
        dtp_pkg::node_addr_t tree_b;  // node address or zero
    } opnd_t;

    typedef struct packed {
        dtp_pkg::node_addr_t left;
        dtp_pkg::node_addr_t right;
        dtp_pkg::node_addr_t tree;
        logic                lt;      // attr < threshold
    } cmp_res_t;

    attr_t               attr_mem [2 ** `DTP_ATTR_W];  // one sample
    attr_t               attr_val, attr_q;
    dtp_pkg::node_addr_t addr_d, hold_addr, wb_addr;
    dtp_pkg::node_word_t word_q;
    dtp_pkg::upd_sel_t   upd_q;
    opnd_t               opnd, opnd_q;
    cmp_res_t            cmp_res, cmp_q;
    logic                is_init;

    always_ff @(posedge clk) begin
        if (i_attr_we) attr_mem[i_attr_addr] <= i_attr_din;
    end

    // -------------------------------------------------
    // decision stage, word back from ram
    // -------------------------------------------------
    delay_line #(.payload_t(dtp_pkg::node_addr_t), .STAGES(`DTP_RAM_STAGES))
        addr_dly_i (.clk(clk), .rst_n(rst_n), .i_data(bus.node_addr), .o_data(addr_d));
    delay_line #(.payload_t(dtp_pkg::node_addr_t),
                 .STAGES(`DTP_PIPE_STAGES - `DTP_RAM_STAGES))
        hold_dly_i (.clk(clk), .rst_n(rst_n), .i_data(addr_d), .o_data(hold_addr));

    assign is_init  = (bus.ctrl_pre == dtp_pkg::CTRL_INIT);
    assign attr_val = attr_mem[bus.node_word[`DTP_ATTR_IDX +: `DTP_ATTR_W]];

    always_comb begin
        opnd.inc = addr_d + dtp_pkg::node_addr_t'(1);
        if (is_init) begin  // root word, absolute target
            opnd.tree_a = bus.node_word[`DTP_AB_TREE_IDX +: `DTP_RAM_AW];
            opnd.tree_b = '0;
        end else begin
            opnd.tree_a = dtp_pkg::node_addr_t'(bus.node_word[`DTP_TREE_IDX +: `DTP_TREE_DEPTH]);
            opnd.tree_b = addr_d;
        end
    end

    // operand register
    delay_line #(.payload_t(attr_t), .STAGES(1))
        attr_dly_i (.clk(clk), .rst_n(rst_n), .i_data(attr_val), .o_data(attr_q));
    delay_line #(.payload_t(dtp_pkg::node_word_t), .STAGES(1))
        word_dly_i (.clk(clk), .rst_n(rst_n), .i_data(bus.node_word), .o_data(word_q));
    delay_line #(.payload_t(opnd_t), .STAGES(1))
        opnd_dly_i (.clk(clk), .rst_n(rst_n), .i_data(opnd), .o_data(opnd_q));
    delay_line #(.payload_t(dtp_pkg::upd_sel_t), .STAGES(1 + `DTP_CMP_STAGES),
                 .RST_VAL(dtp_pkg::UPD_HOLD))
        upd_dly_i (.clk(clk), .rst_n(rst_n), .i_data(bus.upd), .o_data(upd_q));

    // -------------------------------------------------
    // compare and address adders
    // -------------------------------------------------
    always_comb begin
        cmp_res.left  = opnd_q.inc;
        cmp_res.right = opnd_q.inc
                      + dtp_pkg::node_addr_t'(word_q[`DTP_RCHLD_IDX +: `DTP_TREE_DEPTH-1]);
        cmp_res.tree  = opnd_q.tree_a + opnd_q.tree_b;
        cmp_res.lt    = attr_q < word_q[`DTP_THSH_IDX +: `DTP_THSH_W];  // unsigned, equal goes right
    end

    delay_line #(.payload_t(cmp_res_t), .STAGES(`DTP_CMP_STAGES))
        cmp_dly_i (.clk(clk), .rst_n(rst_n), .i_data(cmp_res), .o_data(cmp_q));

    // -------------------------------------------------
    // write back, slot returns to stage 0
    // -------------------------------------------------
    always_comb begin
        case (upd_q)
            dtp_pkg::UPD_CHILD: wb_addr = cmp_q.lt ? cmp_q.left : cmp_q.right;
            dtp_pkg::UPD_TREE:  wb_addr = cmp_q.tree;
            default:            wb_addr = hold_addr;  // hold, leaf retry
        endcase
    end

    always_comb begin
        if (bus.init_sel) begin
            bus.node_addr = dtp_pkg::node_addr_t'(bus.init_node);  // root slot k
        end else if (bus.slot_ctrl == dtp_pkg::CTRL_IDLE) begin
            bus.node_addr = '0;  // idle slots park at 0
        end else begin
            bus.node_addr = wb_addr;
        end
    end
endmodule

// File: delay_line.sv
`timescale 1ns/100ps

module delay_line #(
    parameter type      payload_t = logic,
    parameter int       STAGES    = 1,
    parameter payload_t RST_VAL   = payload_t'(0)
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t i_data,
    output payload_t o_data
);
    payload_t stage_q [STAGES];  // [0] youngest

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                stage_q[i] <= RST_VAL;
            end
        end else begin
            stage_q[0] <= i_data;
            for (int i = 1; i < STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];  // shift
            end
        end
    end

    assign o_data = stage_q[STAGES-1];
endmodule

// File: dtp_control.sv
`timescale 1ns/100ps
`include "dtp_settings.svh"

module dtp_control (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_start,
    input  logic       i_abort,
    output logic       o_done,
    trav_if.control    bus
);
    dtp_pkg::run_state_t     state_q, state_d;
    logic                    pipe_flush;      // start or abort
    logic                    pipeline_start;
    logic                    init_proc;       // root loading active
    logic                    init_end;
    logic                    root_vld, root_done, root_hit;
    logic                    fin;
    logic [`DTP_INIT_AW-1:0] init_node_q, cur_node;

    assign pipe_flush     = ((state_q == dtp_pkg::RUN_IDLE) & i_start) | i_abort;
    assign pipeline_start = (state_q == dtp_pkg::RUN_LOAD);
    assign fin            = bus.all_idle & ~init_proc;
    assign o_done         = (state_q == dtp_pkg::RUN_PROC) & fin & ~i_abort;

    // -------------------------------------------------
    // run state machine
    // -------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) state_q <= dtp_pkg::RUN_IDLE;
        else        state_q <= state_d;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dtp_pkg::RUN_IDLE: if (i_start) state_d = dtp_pkg::RUN_RST;
            dtp_pkg::RUN_RST:  state_d = i_abort ? dtp_pkg::RUN_IDLE : dtp_pkg::RUN_LOAD;
            dtp_pkg::RUN_LOAD: state_d = i_abort ? dtp_pkg::RUN_IDLE : dtp_pkg::RUN_PROC;
            default: begin  // proc
                if (i_abort | fin) state_d = dtp_pkg::RUN_IDLE;
            end
        endcase
    end

    // -------------------------------------------------
    // root loading, one root word per cycle
    // -------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_proc   <= 1'b0;
            init_node_q <= '0;
            root_done   <= 1'b0;
        end else begin
            if (pipe_flush)          init_proc <= 1'b0;
            else if (pipeline_start) init_proc <= 1'b1;
            else if (init_end)       init_proc <= 1'b0;
            init_node_q <= init_proc ? init_node_q + 1'b1 : '0;
            if (pipeline_start)      root_done <= 1'b0;
            else if (root_hit)       root_done <= 1'b1;  // ignore surplus words after last
        end
    end

    // last flag known only RAM_STAGES after the issue
    delay_line #(.payload_t(logic), .STAGES(`DTP_RAM_STAGES))
        vld_dly_i (.clk(clk), .rst_n(rst_n), .i_data(init_proc), .o_data(root_vld));
    delay_line #(.payload_t(logic [`DTP_INIT_AW-1:0]), .STAGES(`DTP_RAM_STAGES))
        node_dly_i (.clk(clk), .rst_n(rst_n), .i_data(init_node_q), .o_data(cur_node));

    assign root_hit = root_vld & ~root_done & bus.node_word[`DTP_LAST_AB_IDX];
    assign init_end = (init_proc & (int'(init_node_q) == `DTP_PIPE_STAGES - 1)) | root_hit;

    assign bus.init_sel  = init_proc;
    assign bus.init_node = init_node_q;

    // -------------------------------------------------
    // flush vector
    // -------------------------------------------------
    // root cur_node sits at stage RAM_STAGES-1, the ones
    // issued after it are younger by j and surplus
    always_comb begin
        bus.flush = '0;
        if (pipe_flush) begin
            bus.flush = '1;
        end else if (root_hit) begin
            for (int j = 1; j <= `DTP_RAM_STAGES; j++) begin
                if (int'(cur_node) + j <= `DTP_PIPE_STAGES - 1) begin
                    bus.flush[`DTP_RAM_STAGES - j] = 1'b1;  // only slots really loaded
                end
            end
        end
    end
endmodule

// File: dtp_pkg.sv
`include "dtp_settings.svh"

package dtp_pkg;

    // -------------------------------------------------
    // per-slot control state
    // -------------------------------------------------
    typedef enum logic [1:0] {
        CTRL_IDLE     = 2'd0,  // slot empty
        CTRL_INIT     = 2'd1,  // root word in flight
        CTRL_INTERNAL = 2'd2   // walking a tree
    } ctrl_state_t;

    // source of the next address for a slot
    typedef enum logic [1:0] {
        UPD_HOLD  = 2'd0,  // same address again
        UPD_CHILD = 2'd1,  // left or right child
        UPD_TREE  = 2'd2   // next tree / root target
    } upd_sel_t;

    // run state machine
    typedef enum logic [1:0] {
        RUN_IDLE = 2'd0,
        RUN_RST  = 2'd1,  // flush everything
        RUN_LOAD = 2'd2,  // kick root loading
        RUN_PROC = 2'd3
    } run_state_t;

    typedef logic [`DTP_RAM_AW-1:0]      node_addr_t;
    typedef logic [`DTP_RAM_DW-1:0]      node_word_t;
    typedef logic [`DTP_PIPE_STAGES-1:0] flush_vec_t;  // one bit per ctrl stage

endpackage

// File: dtp_settings.svh
`ifndef DTP_SETTINGS_SVH
`define DTP_SETTINGS_SVH

// pipeline geometry
`define DTP_PIPE_STAGES  5   // slots in flight
`define DTP_RAM_AW       14  // node address width
`define DTP_RAM_DW       32  // node word width
`define DTP_RAM_STAGES   2   // tree ram read latency
`define DTP_CMP_STAGES   2   // compare / adder latency
`define DTP_TREE_DEPTH   10  // max tree levels
`define DTP_THSH_W       16  // threshold, attribute, result
`define DTP_ATTR_W       5   // attribute select
`define DTP_INIT_AW      3   // root slot counter

// internal node  |rchld 31:22|attr 21:17|thsh 16:1|leaf 0|
`define DTP_LEAF_IDX     0
`define DTP_THSH_IDX     1
`define DTP_ATTR_IDX     17
`define DTP_RCHLD_IDX    22
// leaf node      |tree 27:18|res 17:2|last 1|leaf 0|
`define DTP_LAST_IDX     1
`define DTP_RES_IDX      2
`define DTP_TREE_IDX     18
// root word      |ab_tree 14:1|last_ab 0|
`define DTP_LAST_AB_IDX  0
`define DTP_AB_TREE_IDX  1

`endif

// File: dtp_top.sv
`timescale 1ns/100ps
`include "dtp_settings.svh"

module dtp_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // tree ram load
    input  logic                   i_tree_we,
    input  logic [`DTP_RAM_AW-1:0] i_tree_addr,
    input  logic [`DTP_RAM_DW-1:0] i_tree_din,
    // sample attributes
    input  logic                   i_attr_we,
    input  logic [`DTP_ATTR_W-1:0] i_attr_addr,
    input  logic [`DTP_THSH_W-1:0] i_attr_din,
    // run control
    input  logic                   i_start,   // level
    input  logic                   i_abort,   // pulse
    output logic                   o_done,
    // result sink
    input  logic                   i_res_full,
    output logic                   o_res_valid,
    output logic [`DTP_THSH_W-1:0] o_res_data
);
    trav_if bus ();

    tree_ram tree_ram_i (
        .clk     (clk),
        .i_we    (i_tree_we),
        .i_waddr (i_tree_addr),
        .i_wdata (i_tree_din),
        .bus     (bus.ram)
    );

    node_ctrl node_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_res_full  (i_res_full),
        .o_res_valid (o_res_valid),
        .o_res_data  (o_res_data),
        .bus         (bus.ctrl)
    );

    branch_unit branch_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_attr_we   (i_attr_we),
        .i_attr_addr (i_attr_addr),
        .i_attr_din  (i_attr_din),
        .bus         (bus.branch)
    );

    dtp_control dtp_control_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_start (i_start),
        .i_abort (i_abort),
        .o_done  (o_done),
        .bus     (bus.control)
    );
endmodule

// File: node_ctrl.sv
`timescale 1ns/100ps
`include "dtp_settings.svh"

module node_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_res_full,
    output logic                   o_res_valid,
    output logic [`DTP_THSH_W-1:0] o_res_data,
    trav_if.ctrl                   bus
);
    dtp_pkg::ctrl_state_t ctrl_q [`DTP_PIPE_STAGES];  // one entry per slot
    dtp_pkg::ctrl_state_t ctrl_pre;
    dtp_pkg::ctrl_state_t ctrl_next;
    dtp_pkg::upd_sel_t    upd_next;
    logic                 is_leaf;
    logic                 is_last;
    logic                 idle_all;

    assign ctrl_pre = ctrl_q[`DTP_RAM_STAGES-1];  // same age as node_word
    assign is_leaf  = bus.node_word[`DTP_LEAF_IDX];
    assign is_last  = bus.node_word[`DTP_LAST_IDX];

    // loader overrides the returning slot
    assign bus.slot_ctrl = bus.init_sel ? dtp_pkg::CTRL_INIT : ctrl_q[`DTP_PIPE_STAGES-1];

    // -------------------------------------------------
    // state ring, decision lands at RAM_STAGES
    // -------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `DTP_PIPE_STAGES; i++) begin
                ctrl_q[i] <= dtp_pkg::CTRL_IDLE;
            end
        end else begin
            ctrl_q[0] <= bus.flush[0] ? dtp_pkg::CTRL_IDLE : bus.slot_ctrl;
            for (int i = 1; i < `DTP_PIPE_STAGES; i++) begin
                if (bus.flush[i]) begin
                    ctrl_q[i] <= dtp_pkg::CTRL_IDLE;
                end else if (i == `DTP_RAM_STAGES) begin
                    ctrl_q[i] <= ctrl_next;  // decided state
                end else begin
                    ctrl_q[i] <= ctrl_q[i-1];
                end
            end
        end
    end

    // -------------------------------------------------
    // node decision
    // -------------------------------------------------
    always_comb begin
        ctrl_next = dtp_pkg::CTRL_IDLE;
        upd_next  = dtp_pkg::UPD_HOLD;
        case (ctrl_pre)
            dtp_pkg::CTRL_INIT: begin
                ctrl_next = dtp_pkg::CTRL_INTERNAL;
                upd_next  = dtp_pkg::UPD_TREE;  // jump to root target
            end
            dtp_pkg::CTRL_INTERNAL: begin
                ctrl_next = dtp_pkg::CTRL_INTERNAL;
                if (!is_leaf) begin
                    upd_next = dtp_pkg::UPD_CHILD;
                end else if (i_res_full) begin
                    upd_next = dtp_pkg::UPD_HOLD;  // retry leaf next round
                end else if (is_last) begin
                    ctrl_next = dtp_pkg::CTRL_IDLE;  // chain done
                end else begin
                    upd_next = dtp_pkg::UPD_TREE;
                end
            end
            default: ;
        endcase
    end

    assign bus.ctrl_pre = ctrl_pre;
    assign bus.upd      = upd_next;

    // leaf results straight from the ram word
    assign o_res_valid = (ctrl_pre == dtp_pkg::CTRL_INTERNAL) & is_leaf & ~i_res_full;
    assign o_res_data  = bus.node_word[`DTP_RES_IDX +: `DTP_THSH_W];

    always_comb begin
        idle_all = 1'b1;
        for (int i = 0; i < `DTP_PIPE_STAGES; i++) begin
            if (ctrl_q[i] != dtp_pkg::CTRL_IDLE) idle_all = 1'b0;
        end
    end
    assign bus.all_idle = idle_all;
endmodule

// File: run.sh
#!/bin/sh
# compile and run the testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f src.f --top-module tb_dtp -o sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^>>> PASS$"; then
    exit 0
fi
exit 1

// File: src.f
+incdir+.
dtp_pkg.sv
trav_if.sv
delay_line.sv
tree_ram.sv
node_ctrl.sv
branch_unit.sv
dtp_control.sv
dtp_top.sv
tb_clk_gen.sv
tb_dtp.sv

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);
    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;  // 100 ns period
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (4) @(posedge o_clk);  // 4 cycles in reset
        #10 o_rst_n = 1'b1;
    end
endmodule

// File: tb_dtp.sv
`timescale 1ns/100ps
`include "dtp_settings.svh"

module tb_dtp;
    logic                   clk, rst_n;
    logic                   i_tree_we, i_attr_we, i_start, i_abort, i_res_full;
    logic [`DTP_RAM_AW-1:0] i_tree_addr;
    logic [`DTP_RAM_DW-1:0] i_tree_din;
    logic [`DTP_ATTR_W-1:0] i_attr_addr;
    logic [`DTP_THSH_W-1:0] i_attr_din;
    logic                   o_done, o_res_valid;
    logic [`DTP_THSH_W-1:0] o_res_data;

    logic [31:0] rng = 32'd33945;
    logic [31:0] img [0:1023];           // forest image, low part of the ram
    logic [15:0] attr_arr [0:31];        // copy of the sample
    logic [15:0] exp_q [$];              // results still owed
    logic [15:0] stray;
    int          top, got_cnt, bad_cnt, done_cnt, pass_cnt, fail_cnt;
    bit          collecting, timed_out;

    tb_clk_gen clk_gen_i (.o_clk(clk), .o_rst_n(rst_n));

    dtp_top dut_i (.*);

    function automatic logic [31:0] xs();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // --------------------------------------------------
    // forest builder
    // --------------------------------------------------
    function automatic int root_of(int c, int t);
        return 8 + (t * 5 + c) * 32;     // 32-word block per tree
    endfunction

    // preorder layout, returns subtree size
    function automatic int build_node(int addr, int d, int nxt, bit last);
        int lsz;
        int rsz;
        if (d == 0 || xs() % 3 == 0) begin
            img[addr] = {4'd0, 10'(nxt - addr), 16'(xs()), last, 1'b1};  // leaf
            return 1;
        end
        lsz = build_node(addr + 1, d - 1, nxt, last);
        rsz = build_node(addr + 1 + lsz, d - 1, nxt, last);
        img[addr] = {1'b0, 9'(lsz), 5'(xs()), 16'(xs()), 1'b0};
        return 1 + lsz + rsz;
    endfunction

    function automatic void build_forest(int nch, int ntr);
        for (int a = 0; a < 1024; a++) img[a] = 32'd0;
        for (int c = 0; c < nch; c++) begin
            img[c] = {17'd0, 14'(root_of(c, 0)), c == nch - 1};  // root pointer
            for (int t = 0; t < ntr; t++) begin
                void'(build_node(root_of(c, t), xs() % 5, root_of(c, t + 1), t == ntr - 1));
            end
        end
        top = root_of(0, ntr);
    endfunction

    // --------------------------------------------------
    // reference model, walks every chain by the node rule
    // --------------------------------------------------
    function automatic void expect_forest();
        int  addr;
        int  steps;
        logic [31:0] w;
        exp_q.delete();
        for (int k = 0; k < 5; k++) begin
            addr  = img[k][14:1];
            steps = 0;
            while (steps < 1000) begin
                w = img[addr];
                steps++;
                if (w[0]) begin
                    exp_q.push_back(w[17:2]);
                    if (w[1]) break;     // end of chain
                    addr = addr + w[27:18];
                end else if (attr_arr[w[21:17]] < w[16:1]) begin
                    addr = addr + 1;     // strictly less goes left
                end else begin
                    addr = addr + 1 + w[30:22];
                end
            end
            if (img[k][0]) break;        // last root
        end
    endfunction

    task automatic load_all();
        for (int a = 0; a < top; a++) begin
            @(posedge clk);
            #10;
            i_tree_we = 1'b1;
            i_tree_addr = a;
            i_tree_din = img[a];
        end
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #10;
            i_tree_we = 1'b0;
            i_attr_we = 1'b1;
            i_attr_addr = i;
            i_attr_din = attr_arr[i];
        end
        @(posedge clk);
        #10 i_attr_we = 1'b0;
    endtask

    // --------------------------------------------------
    // checker, marks results off the expected list
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (o_done) done_cnt++;
            if (o_res_valid && collecting) begin
                got_cnt++;
                begin : find
                    foreach (exp_q[i]) begin
                        if (exp_q[i] == o_res_data) begin
                            exp_q.delete(i);
                            disable find;
                        end
                    end
                    bad_cnt++;           // no match left
                    stray = o_res_data;
                end
            end
        end
    end

    task automatic pulse_start();
        got_cnt = 0;
        bad_cnt = 0;
        done_cnt = 0;
        @(posedge clk);
        #10 i_start = 1'b1;
        @(posedge clk);
        #10 i_start = 1'b0;
    endtask

    task automatic run_check(string name, bit rand_full);
        int n_exp;
        int limit;
        int cyc;
        n_exp = exp_q.size();
        limit = 200 * n_exp + 1000;
        collecting = 1'b1;
        pulse_start();
        cyc = 0;
        while (done_cnt == 0) begin
            @(posedge clk);
            #10;
            if (rand_full) i_res_full = 1'(xs() >> 3);  // sink busy at random
            cyc++;
            if (cyc > limit) begin
                timed_out = 1'b1;
                break;
            end
        end
        i_res_full = 1'b0;
        repeat (10) @(posedge clk);  // catch late duplicates
        collecting = 1'b0;
        if (timed_out) begin
            $display("test %s timed out after %0d cycles without done", name, cyc);
            fail_cnt++;
        end else if (got_cnt != n_exp) begin
            $display("[FAIL] %s count expected %0d actual %0d", name, n_exp, got_cnt);
            fail_cnt++;
        end else if (bad_cnt != 0) begin
            $display("[FAIL] %s result expected one of list actual 0x%h", name, stray);
            fail_cnt++;
        end else begin
            $display("[PASS] %s results %0d", name, got_cnt);
            pass_cnt++;
        end
    endtask

    task automatic random_sample();
        for (int i = 0; i < 32; i++) attr_arr[i] = 16'(xs());
    endtask

    // equal goes right, then less goes left
    task automatic hand_tree();
        for (int a = 0; a < 16; a++) img[a] = 32'd0;
        img[0]  = {17'd0, 14'd8, 1'b1};
        img[8]  = {1'b0, 9'd1, 5'd3, 16'h1234, 1'b0};
        img[9]  = {4'd0, 10'd0, 16'haaaa, 1'b1, 1'b1};
        img[10] = {1'b0, 9'd1, 5'd4, 16'h1234, 1'b0};
        img[11] = {4'd0, 10'd0, 16'hcccc, 1'b1, 1'b1};
        img[12] = {4'd0, 10'd0, 16'hdddd, 1'b1, 1'b1};
        top = 16;
        attr_arr[3] = 16'h1234;
        attr_arr[4] = 16'h1233;
    endtask

    initial begin
        i_tree_we = 1'b0;
        i_tree_addr = '0;
        i_tree_din = '0;
        i_attr_we = 1'b0;
        i_attr_addr = '0;
        i_attr_din = '0;
        i_start = 1'b0;
        i_abort = 1'b0;
        i_res_full = 1'b0;
        collecting = 1'b0;
        timed_out = 1'b0;
        pass_cnt = 0;
        fail_cnt = 0;
        @(posedge rst_n);

        random_sample();
        build_forest(1, 1);
        load_all();
        expect_forest();
        run_check("single_tree", 1'b0);

        if (!timed_out) begin
            random_sample();
            build_forest(5, 3);
            load_all();
            expect_forest();
            run_check("five_chains", 1'b0);
        end

        if (!timed_out) begin
            random_sample();
            hand_tree();
            load_all();
            exp_q.delete();
            exp_q.push_back(16'hcccc);
            run_check("equal_right", 1'b0);
        end

        if (!timed_out) begin
            random_sample();
            build_forest(5, 2);
            load_all();
            expect_forest();
            run_check("sink_full", 1'b1);
        end

        if (!timed_out) begin
            random_sample();
            build_forest(5, 3);
            load_all();
            pulse_start();               // results of this run are ignored
            repeat (20) @(posedge clk);
            #10 i_abort = 1'b1;
            @(posedge clk);
            #10 i_abort = 1'b0;
            repeat (300) @(posedge clk);
            if (done_cnt != 0) begin
                $display("[FAIL] abort done expected 0 actual %0d", done_cnt);
                fail_cnt++;
            end else begin
                $display("[PASS] abort");
                pass_cnt++;
            end
            expect_forest();
            run_check("after_abort", 1'b0);
        end

        $display("tests %0d passed %0d failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end
endmodule

// File: trav_if.sv
`timescale 1ns/100ps
`include "dtp_settings.svh"

interface trav_if;
    dtp_pkg::node_addr_t  node_addr;  // address issued this cycle
    dtp_pkg::node_word_t  node_word;  // ram word, RAM_STAGES later
    dtp_pkg::ctrl_state_t ctrl_pre;   // state lined up with node_word
    dtp_pkg::upd_sel_t    upd;        // address source picked by the decision
    dtp_pkg::ctrl_state_t slot_ctrl;  // state entering stage 0
    logic                 all_idle;
    logic                 init_sel;   // root loading owns the issue port
    logic [`DTP_INIT_AW-1:0] init_node;
    dtp_pkg::flush_vec_t  flush;

    modport ram     (input node_addr, output node_word);

    modport ctrl    (input node_word, init_sel, flush,
                     output ctrl_pre, upd, slot_ctrl, all_idle);

    modport branch  (input node_word, ctrl_pre, upd, slot_ctrl, init_sel, init_node,
                     output node_addr);

    modport control (input node_word, all_idle,
                     output init_sel, init_node, flush);
endinterface

// File: tree_ram.sv
`timescale 1ns/100ps
`include "dtp_settings.svh"

module tree_ram (
    input  logic                clk,
    input  logic                i_we,
    input  dtp_pkg::node_addr_t i_waddr,
    input  dtp_pkg::node_word_t i_wdata,
    trav_if.ram                 bus
);
    localparam int DEPTH = 2 ** `DTP_RAM_AW;

    dtp_pkg::node_word_t mem [DEPTH];  // whole forest
    dtp_pkg::node_word_t rd_q;         // array read register
    dtp_pkg::node_word_t out_q;        // output register

    // -------------------------------------------------
    // load port
    // -------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // -------------------------------------------------
    // pipeline read, two stages
    // -------------------------------------------------
    always_ff @(posedge clk) begin
        rd_q  <= mem[bus.node_addr];
        out_q <= rd_q;
    end

    // word lines up with ctrl_pre in node_ctrl
    assign bus.node_word = out_q;
endmodule
